// File: verilog.f
+incdir+.
dehaze_pkg.sv
window_mean_stage.sv
transmission_stage.sv
reciprocal_lut.sv
scene_recovery_stage.sv
dehaze_top.sv
tb_dehaze.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dehazing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dehaze -f verilog.f -o tb_dehaze_sim
./obj_dir/tb_dehaze_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^all tests passed$" sim.log; then
    exit 0
fi
exit 1

// File: tb_dehaze_model.svh
// Reference model for the expected recovered pixel of one window
`ifndef TB_DEHAZE_MODEL_SVH
`define TB_DEHAZE_MODEL_SVH

function automatic pixel_t expected_pixel(input pixel_t w [9], input chan_t a [3],
                                          input inv_q16_t inv [3]);
    int mean [3];
    int res [3];
    int sum;
    int pick;
    int prod;
    int idx;
    int recip;
    int pix;
    int diff;
    int gain;

    // Per-channel 3x3 mean, divide by nine through multiply and shift
    for (int c = 0; c < 3; c++) begin
        sum = 0;
        for (int k = 0; k < 9; k++) begin
            sum = sum + int'(w[k][8*(2-c) +: 8]);
        end
        mean[c] = (sum * int'(MEAN_MUL)) >> MEAN_SHIFT;
    end

    // Dark channel, red first on a tie, then green
    pick = 0;
    if (mean[1] < mean[pick]) begin
        pick = 1;
    end
    if (mean[2] < mean[pick]) begin
        pick = 2;
    end

    // Mean times omega-scaled inverse, saturated Q0.14
    prod = (mean[pick] * (int'(inv[pick]) - (int'(inv[pick]) >> OMEGA_SHIFT))) >> PROD_SHIFT;
    if (prod > int'(TRANS_ONE)) begin
        prod = int'(TRANS_ONE);
    end

    // Top bits of t pick the reciprocal, small t floored
    idx = (int'(TRANS_ONE) - prod) >> ($bits(trans_q14_t) - RECIP_INDEX_BITS);
    if (idx < int'(T_MIN_INDEX)) begin
        idx = int'(T_MIN_INDEX);
    end
    recip = 65536 / idx;

    for (int c = 0; c < 3; c++) begin
        pix  = int'(w[4][8*(2-c) +: 8]);
        diff = (pix >= int'(a[c])) ? pix - int'(a[c]) : int'(a[c]) - pix;
        gain = (diff * recip) >> 8;
        if (gain > 255) begin
            gain = 255;
        end
        if (pix >= int'(a[c])) begin
            res[c] = (int'(a[c]) + gain > 255) ? 255 : int'(a[c]) + gain;
        end else begin
            res[c] = (gain > int'(a[c])) ? 0 : int'(a[c]) - gain;
        end
    end
    return pixel_t'((res[0] << 16) | (res[1] << 8) | res[2]);
endfunction

`endif

// File: tb_dehaze.sv
// Dehazing testbench with stimulus phases, expected-pixel queue, compare process and watchdog
`timescale 1ns/1ns

module tb_dehaze import dehaze_pkg::*; ();

    localparam int N_UNIFORM    = 16;
    localparam int N_RANDOM     = 300;
    localparam int N_DENSE      = 40;
    localparam int N_GAP_SLOTS  = 150;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_SLOTS   = N_UNIFORM + N_RANDOM + N_DENSE + N_GAP_SLOTS;
    localparam int WATCHDOG_CYCLES = TEST_SLOTS + RESET_CYCLES + PIPE_LATENCY + 50;

    `include "tb_dehaze_model.svh"

    logic     clk = 1'b0;
    logic     rst;
    logic     input_valid;
    pixel_t   win [9];
    chan_t    a_light [3];
    inv_q16_t inv_light [3];
    chan_t    j_r, j_g, j_b;
    logic     output_valid;

    // Values for the next slot are built before the clock edge
    pixel_t   next_win [9];
    chan_t    next_a [3];
    inv_q16_t next_inv [3];

    pixel_t   exp_q [$];
    int       cyc_q [$];
    int       seed = 32'h03d395a4;
    int       error_count = 0;
    int       checked_count = 0;
    int       cycle_count = 0;

    dehaze_top DUT (
        .clk(clk), .rst(rst), .input_valid(input_valid),
        .input_pixel_1(win[0]), .input_pixel_2(win[1]), .input_pixel_3(win[2]),
        .input_pixel_4(win[3]), .input_pixel_5(win[4]), .input_pixel_6(win[5]),
        .input_pixel_7(win[6]), .input_pixel_8(win[7]), .input_pixel_9(win[8]),
        .a_r(a_light[0]), .a_g(a_light[1]), .a_b(a_light[2]),
        .inv_ar(inv_light[0]), .inv_ag(inv_light[1]), .inv_ab(inv_light[2]),
        .j_r(j_r), .j_g(j_g), .j_b(j_b),
        .output_valid(output_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic chan_t rand_byte();
        int r;
        r = $random(seed);
        return chan_t'(r);
    endfunction

    // Inverse light is gain * 65536 / A saturated to 16 bits
    function automatic inv_q16_t inverse_light(input chan_t a, input int gain);
        int v;
        v = (gain << 16) / int'(a);
        return (v > 65535) ? 16'hffff : inv_q16_t'(v);
    endfunction

    task automatic set_light(input int low, input int gain);
        for (int c = 0; c < 3; c++) begin
            next_a[c]   = chan_t'(low + int'(rand_byte()) % (256 - low));
            next_inv[c] = inverse_light(next_a[c], gain);
        end
    endtask

    // Gray windows give equal channel means and so exercise the tie rule
    task automatic fill_random_window(input logic gray);
        chan_t v;
        for (int k = 0; k < 9; k++) begin
            v = rand_byte();
            next_win[k] = gray ? {v, v, v} : {rand_byte(), rand_byte(), v};
        end
    endtask

    // Neighbours lie within 2 of A and the center from 40 below to 10 above A
    task automatic fill_dense_window();
        int v;
        for (int k = 0; k < 9; k++) begin
            for (int c = 0; c < 3; c++) begin
                if (k == 4) begin
                    v = int'(next_a[c]) + int'(rand_byte()) % 51 - 40;
                end else begin
                    v = int'(next_a[c]) + int'(rand_byte()) % 5 - 2;
                end
                v = (v < 0) ? 0 : (v > 255) ? 255 : v;
                next_win[k][8*(2-c) +: 8] = chan_t'(v);
            end
        end
    endtask

    task automatic apply_slot(input logic valid);
        @(posedge clk);
        input_valid <= valid;
        for (int k = 0; k < 9; k++) begin
            win[k] <= next_win[k];
        end
        for (int c = 0; c < 3; c++) begin
            a_light[c]   <= next_a[c];
            inv_light[c] <= next_inv[c];
        end
    endtask

    task automatic check_idle_outputs();
        @(negedge clk);
        if (output_valid !== 1'b0) begin
            error_count++;
            $display("Mismatch output_valid: got %h, expected %h at cycle %0d",
                     output_valid, 1'b0, cycle_count);
        end
        if (j_r !== 8'h00) begin
            error_count++;
            $display("Mismatch j_r: got %h, expected %h at cycle %0d", j_r, 8'h00, cycle_count);
        end
        if (j_g !== 8'h00) begin
            error_count++;
            $display("Mismatch j_g: got %h, expected %h at cycle %0d", j_g, 8'h00, cycle_count);
        end
        if (j_b !== 8'h00) begin
            error_count++;
            $display("Mismatch j_b: got %h, expected %h at cycle %0d", j_b, 8'h00, cycle_count);
        end
    endtask

    // ==================================================
    // Compare process
    // ==================================================

    always @(posedge clk) begin
        pixel_t want;
        int     sent;
        if (input_valid) begin
            exp_q.push_back(expected_pixel(win, a_light, inv_light));
            cyc_q.push_back(cycle_count);
        end
        if (output_valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("output_valid high at cycle %0d with no window in flight", cycle_count);
            end else begin
                want = exp_q.pop_front();
                sent = cyc_q.pop_front();
                checked_count++;
                if (cycle_count - sent != PIPE_LATENCY) begin
                    error_count++;
                    $display("Window from cycle %0d came out after %0d cycles instead of %0d",
                             sent, cycle_count - sent, PIPE_LATENCY);
                end
                if (j_r !== want[23:16]) begin
                    error_count++;
                    $display("Mismatch j_r: got %h, expected %h", j_r, want[23:16]);
                end
                if (j_g !== want[15:8]) begin
                    error_count++;
                    $display("Mismatch j_g: got %h, expected %h", j_g, want[15:8]);
                end
                if (j_b !== want[7:0]) begin
                    error_count++;
                    $display("Mismatch j_b: got %h, expected %h", j_b, want[7:0]);
                end
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        rst         = 1'b1;
        input_valid = 1'b0;
        for (int k = 0; k < 9; k++) begin
            win[k]      = '0;
            next_win[k] = '0;
        end
        for (int c = 0; c < 3; c++) begin
            a_light[c]   = '0;
            inv_light[c] = '0;
            next_a[c]    = '0;
            next_inv[c]  = '0;
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            check_idle_outputs();
        end
        repeat (4) check_idle_outputs();

        // Uniform haze with every window pixel equal to A
        for (int i = 0; i < N_UNIFORM; i++) begin
            set_light(64, 64);
            for (int k = 0; k < 9; k++) begin
                next_win[k] = {next_a[0], next_a[1], next_a[2]};
            end
            apply_slot(1'b1);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            set_light(64, 64);
            fill_random_window(i % 8 == 0);
            apply_slot(1'b1);
        end

        // Dense haze with bright A and a near-saturated inverse
        for (int i = 0; i < N_DENSE; i++) begin
            set_light(245, 256);
            fill_dense_window();
            apply_slot(1'b1);
        end

        // Idle slots on about a third of the cycles
        for (int i = 0; i < N_GAP_SLOTS; i++) begin
            set_light(64, 64);
            fill_random_window(1'b0);
            apply_slot(rand_byte() % 3 != 0);
        end
        apply_slot(1'b0);

        for (int i = 0; i < 2 * PIPE_LATENCY && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        // Further cycles catch any late extra output_valid pulse
        repeat (PIPE_LATENCY) @(posedge clk);
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d windows never produced an output", exp_q.size());
        end

        $display("Checked %0d outputs, %0d errors", checked_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, error_count);
        $display("tests failed");
        $finish;
    end

endmodule

// File: dehaze_top.sv
// Dehazing pipeline top level connecting the mean, transmission, table and recovery stages
`timescale 1ns/1ns

// Window in, recovered pixel out PIPE_LATENCY (7) cycles later, in input order
module dehaze_top import dehaze_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     input_valid,
    input  pixel_t   input_pixel_1,
    input  pixel_t   input_pixel_2,
    input  pixel_t   input_pixel_3,
    input  pixel_t   input_pixel_4,
    input  pixel_t   input_pixel_5,
    input  pixel_t   input_pixel_6,
    input  pixel_t   input_pixel_7,
    input  pixel_t   input_pixel_8,
    input  pixel_t   input_pixel_9,
    input  chan_t    a_r,
    input  chan_t    a_g,
    input  chan_t    a_b,
    input  inv_q16_t inv_ar,
    input  inv_q16_t inv_ag,
    input  inv_q16_t inv_ab,
    output chan_t    j_r,
    output chan_t    j_g,
    output chan_t    j_b,
    output logic     output_valid
);

    // Mean stage to transmission stage
    chan_t      mean_r, mean_g, mean_b;
    inv_q16_t   inv_r, inv_g, inv_b;
    pixel_t     center_m;
    chan_t      a_r_m, a_g_m, a_b_m;
    logic       valid_m;

    // Transmission stage to table and recovery stage
    trans_q14_t transmission;
    pixel_t     center_t;
    chan_t      a_r_t, a_g_t, a_b_t;
    logic       valid_t;

    recip_t     recip;

    window_mean_stage u_mean (
        .clk(clk), .rst(rst), .input_valid(input_valid),
        .p1(input_pixel_1), .p2(input_pixel_2), .p3(input_pixel_3),
        .p4(input_pixel_4), .p5(input_pixel_5), .p6(input_pixel_6),
        .p7(input_pixel_7), .p8(input_pixel_8), .p9(input_pixel_9),
        .a_r(a_r), .a_g(a_g), .a_b(a_b),
        .inv_ar(inv_ar), .inv_ag(inv_ag), .inv_ab(inv_ab),
        .mean_r(mean_r), .mean_g(mean_g), .mean_b(mean_b),
        .inv_r(inv_r), .inv_g(inv_g), .inv_b(inv_b),
        .center(center_m),
        .a_r_o(a_r_m), .a_g_o(a_g_m), .a_b_o(a_b_m),
        .valid(valid_m)
    );

    transmission_stage u_trans (
        .clk(clk), .rst(rst), .valid_in(valid_m),
        .mean_r(mean_r), .mean_g(mean_g), .mean_b(mean_b),
        .inv_r(inv_r), .inv_g(inv_g), .inv_b(inv_b),
        .center(center_m),
        .a_r(a_r_m), .a_g(a_g_m), .a_b(a_b_m),
        .transmission(transmission),
        .center_o(center_t),
        .a_r_o(a_r_t), .a_g_o(a_g_t), .a_b_o(a_b_t),
        .valid(valid_t)
    );

    // Lookup runs alongside the first recovery level
    reciprocal_lut u_recip (
        .clk(clk), .rst(rst),
        .transmission(transmission),
        .recip(recip)
    );

    scene_recovery_stage u_recover (
        .clk(clk), .rst(rst), .valid_in(valid_t),
        .center(center_t),
        .a_r(a_r_t), .a_g(a_g_t), .a_b(a_b_t),
        .recip(recip),
        .j_r(j_r), .j_g(j_g), .j_b(j_b),
        .valid(output_valid)
    );

endmodule

// File: scene_recovery_stage.sv
// Scene recovery: absolute difference, reciprocal scaling, add or subtract and clamp
`timescale 1ns/1ns

module scene_recovery_stage import dehaze_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_in,
    input  pixel_t center,
    input  chan_t  a_r,
    input  chan_t  a_g,
    input  chan_t  a_b,
    input  recip_t recip,
    output chan_t  j_r,
    output chan_t  j_g,
    output chan_t  j_b,
    output logic   valid
);

    // Index 0 is red throughout
    chan_t       pix [3];
    chan_t       a_in [3];
    chan_t       diff_d [3];
    logic        ge_d [3];

    // Level 1, aligned with the table lookup
    chan_t       diff_q [3];
    logic        ge_q [3];
    chan_t       a_q [3];
    logic        valid_q;

    logic [23:0] prod [3];
    chan_t       mult_d [3];

    // Level 2
    chan_t       mult_q [3];
    logic        ge_q2 [3];
    chan_t       a_q2 [3];
    logic        valid_q2;

    logic [8:0]  add_sum [3];
    chan_t       out_d [3];

    assign pix[0]  = center[23:16];
    assign pix[1]  = center[15:8];
    assign pix[2]  = center[7:0];
    assign a_in[0] = a_r;
    assign a_in[1] = a_g;
    assign a_in[2] = a_b;

    // ==================================================
    // |I - A| and direction
    // ==================================================

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            ge_d[c]   = (pix[c] >= a_in[c]);
            diff_d[c] = ge_d[c] ? pix[c] - a_in[c] : a_in[c] - pix[c];
        end
    end

    always_ff @(posedge clk) begin
        diff_q <= diff_d;
        ge_q   <= ge_d;
        a_q    <= a_in;
    end

    // ==================================================
    // Scale by 1/t, drop the Q8.8 fraction
    // ==================================================

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            prod[c]   = diff_q[c] * recip;
            mult_d[c] = (prod[c][23:16] != 8'd0) ? 8'd255 : prod[c][15:8];
        end
    end

    always_ff @(posedge clk) begin
        mult_q <= mult_d;
        ge_q2  <= ge_q;
        a_q2   <= a_q;
    end

    // ==================================================
    // J = A +/- scaled difference, clamped
    // ==================================================

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            add_sum[c] = {1'b0, a_q2[c]} + {1'b0, mult_q[c]};
            if (ge_q2[c]) begin
                out_d[c] = add_sum[c][8] ? 8'd255 : add_sum[c][7:0];
            end else begin
                out_d[c] = (mult_q[c] > a_q2[c]) ? 8'd0 : a_q2[c] - mult_q[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= 1'b0;
            valid_q2 <= 1'b0;
            valid    <= 1'b0;
            j_r      <= '0;
            j_g      <= '0;
            j_b      <= '0;
        end else begin
            valid_q  <= valid_in;
            valid_q2 <= valid_q;
            valid    <= valid_q2;
            j_r      <= out_d[0];
            j_g      <= out_d[1];
            j_b      <= out_d[2];
        end
    end

endmodule

// File: reciprocal_lut.sv
// Registered 256-entry table of Q8.8 transmission reciprocals with a lower floor
`timescale 1ns/1ns

module reciprocal_lut import dehaze_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  trans_q14_t transmission,
    output recip_t     recip
);

    localparam int ENTRIES = 2 ** RECIP_INDEX_BITS;

    recip_t                      rom [ENTRIES];
    logic [RECIP_INDEX_BITS-1:0] idx;

    // 1/t in Q8.8 is 65536 / k for t = k/256, small k clamped to the floor
    function automatic recip_t recip_entry(input int k);
        int divisor;
        divisor = (k < int'(T_MIN_INDEX)) ? int'(T_MIN_INDEX) : k;
        return recip_t'(65536 / divisor);
    endfunction

    for (genvar k = 0; k < ENTRIES; k++) begin : g_rom
        assign rom[k] = recip_entry(k);
    end

    // Top bits of the transmission select the entry
    assign idx = transmission[$bits(trans_q14_t)-1 -: RECIP_INDEX_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            recip <= '0;
        end else begin
            recip <= rom[idx];
        end
    end

endmodule

// File: transmission_stage.sv
// Dark-channel minimum selection, Q0.14 product and transmission register
`timescale 1ns/1ns

module transmission_stage import dehaze_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_in,
    input  chan_t      mean_r,
    input  chan_t      mean_g,
    input  chan_t      mean_b,
    input  inv_q16_t   inv_r,
    input  inv_q16_t   inv_g,
    input  inv_q16_t   inv_b,
    input  pixel_t     center,
    input  chan_t      a_r,
    input  chan_t      a_g,
    input  chan_t      a_b,
    output trans_q14_t transmission,
    output pixel_t     center_o,
    output chan_t      a_r_o,
    output chan_t      a_g_o,
    output chan_t      a_b_o,
    output logic       valid
);

    chan_t       min_mean;
    inv_q16_t    min_inv;
    logic [23:0] prod;
    logic [23:0] prod_shift;
    trans_q14_t  prod_sat;

    // First register level
    trans_q14_t  prod_q;
    pixel_t      center_q;
    chan_t       a_q [3];
    logic        valid_q;

    // ==================================================
    // Minimum channel and product
    // ==================================================

    always_comb begin
        // On a tie red wins over green, green over blue
        if (mean_r <= mean_g && mean_r <= mean_b) begin
            min_mean = mean_r;
            min_inv  = inv_r;
        end else if (mean_g <= mean_b) begin
            min_mean = mean_g;
            min_inv  = inv_g;
        end else begin
            min_mean = mean_b;
            min_inv  = inv_b;
        end

        prod       = min_mean * min_inv;
        prod_shift = prod >> PROD_SHIFT;
        if (prod_shift > TRANS_ONE) begin
            prod_sat = TRANS_ONE;
        end else begin
            prod_sat = trans_q14_t'(prod_shift);
        end
    end

    always_ff @(posedge clk) begin
        prod_q   <= prod_sat;
        center_q <= center;
        a_q[0]   <= a_r;
        a_q[1]   <= a_g;
        a_q[2]   <= a_b;
    end

    // ==================================================
    // Transmission, t = 1 - product
    // ==================================================

    always_ff @(posedge clk) begin
        transmission <= TRANS_ONE - prod_q;
        center_o     <= center_q;
        a_r_o        <= a_q[0];
        a_g_o        <= a_q[1];
        a_b_o        <= a_q[2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            valid   <= 1'b0;
        end else begin
            valid_q <= valid_in;
            valid   <= valid_q;
        end
    end

endmodule

// File: window_mean_stage.sv
// Window input registers, per-channel 3x3 means and omega scaling of the inverse light
`timescale 1ns/1ns

module window_mean_stage import dehaze_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     input_valid,
    input  pixel_t   p1,
    input  pixel_t   p2,
    input  pixel_t   p3,
    input  pixel_t   p4,
    input  pixel_t   p5,
    input  pixel_t   p6,
    input  pixel_t   p7,
    input  pixel_t   p8,
    input  pixel_t   p9,
    input  chan_t    a_r,
    input  chan_t    a_g,
    input  chan_t    a_b,
    input  inv_q16_t inv_ar,
    input  inv_q16_t inv_ag,
    input  inv_q16_t inv_ab,
    output chan_t    mean_r,
    output chan_t    mean_g,
    output chan_t    mean_b,
    output inv_q16_t inv_r,
    output inv_q16_t inv_g,
    output inv_q16_t inv_b,
    output pixel_t   center,
    output chan_t    a_r_o,
    output chan_t    a_g_o,
    output chan_t    a_b_o,
    output logic     valid
);

    // First register level, index 0 is red
    pixel_t      win_q [9];
    chan_t       a_q [3];
    inv_q16_t    inv_q [3];
    logic        valid_q;

    logic [11:0] sum [3];
    logic [24:0] scaled [3];
    chan_t       mean_d [3];
    inv_q16_t    inv_d [3];

    // ==================================================
    // Input registers
    // ==================================================

    always_ff @(posedge clk) begin
        win_q[0] <= p1;
        win_q[1] <= p2;
        win_q[2] <= p3;
        win_q[3] <= p4;
        win_q[4] <= p5;
        win_q[5] <= p6;
        win_q[6] <= p7;
        win_q[7] <= p8;
        win_q[8] <= p9;
        a_q[0]   <= a_r;
        a_q[1]   <= a_g;
        a_q[2]   <= a_b;
        inv_q[0] <= inv_ar;
        inv_q[1] <= inv_ag;
        inv_q[2] <= inv_ab;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= input_valid;
        end
    end

    // ==================================================
    // Means and omega scaling
    // ==================================================

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            sum[c] = '0;
            for (int k = 0; k < 9; k++) begin
                sum[c] = sum[c] + 12'(win_q[k][8*(2-c) +: 8]);
            end
            // Divide by nine through a reciprocal multiply
            scaled[c] = sum[c] * MEAN_MUL;
            mean_d[c] = chan_t'(scaled[c] >> MEAN_SHIFT);
            inv_d[c]  = inv_q[c] - (inv_q[c] >> OMEGA_SHIFT);
        end
    end

    always_ff @(posedge clk) begin
        mean_r <= mean_d[0];
        mean_g <= mean_d[1];
        mean_b <= mean_d[2];
        inv_r  <= inv_d[0];
        inv_g  <= inv_d[1];
        inv_b  <= inv_d[2];
        center <= win_q[4];
        a_r_o  <= a_q[0];
        a_g_o  <= a_q[1];
        a_b_o  <= a_q[2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_q;
        end
    end

endmodule

// File: dehaze_pkg.sv
// Pixel and fixed-point types, mean, omega, transmission and reciprocal constants

package dehaze_pkg;

    // ==================================================
    // Data types
    // ==================================================

    // One 8-bit colour channel
    typedef logic [7:0]  chan_t;

    // RGB pixel, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] pixel_t;

    // Inverse atmospheric light, Q0.16
    typedef logic [15:0] inv_q16_t;

    // Transmission, Q0.14
    typedef logic [13:0] trans_q14_t;

    // Reciprocal of the transmission, Q8.8
    typedef logic [15:0] recip_t;

    // ==================================================
    // Window mean
    // ==================================================

    // sum * 7282 >> 16 is close to sum / 9
    localparam logic [12:0] MEAN_MUL   = 13'd7282;
    localparam int          MEAN_SHIFT = 16;

    // ==================================================
    // Transmission
    // ==================================================

    // omega = 63/64, applied as inv - (inv >> 6)
    localparam int         OMEGA_SHIFT = 6;

    // Q8 mean times Q0.16 inverse gives Q0.24, shift down to Q0.14
    localparam int         PROD_SHIFT  = 10;
    localparam trans_q14_t TRANS_ONE   = 14'd16383;

    // ==================================================
    // Reciprocal table and pipeline
    // ==================================================

    localparam int         RECIP_INDEX_BITS = 8;

    // Index floor, roughly t = 0.1
    localparam logic [7:0] T_MIN_INDEX      = 8'd26;

    // Cycles from an accepted window to its output pixel
    localparam int         PIPE_LATENCY     = 7;

endpackage
